// ==== logic/periph_defines.svh ====
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Bus widths
`define PERIPH_DATA_W       32
`define PERIPH_ADDR_W       12

// Timer row
`define PERIPH_NUM_TIMERS   4
`define PERIPH_IRQ_ID_W     2

// Address map, byte addresses
// Channel k sits at k * stride, the event unit gets one stride-sized window
`define PERIPH_CHAN_STRIDE  16
`define PERIPH_EVU_BASE     256

`endif

// ==== logic/bus_pkg.sv ====
`include "periph_defines.svh"

package bus_pkg;

  typedef logic [`PERIPH_DATA_W-1:0] data_t;
  typedef logic [`PERIPH_ADDR_W-1:0] addr_t;

  // Word offsets inside one channel window
  typedef enum logic [1:0] {
    COUNT   = 2'd0,
    COMPARE = 2'd1,
    CTRL    = 2'd2,
    STATUS  = 2'd3
  } timer_reg_e;

  typedef enum logic {
    IDLE = 1'b0,
    ACK  = 1'b1
  } wb_state_e;

endpackage

// ==== logic/irq_pkg.sv ====
`include "periph_defines.svh"

package irq_pkg;

  typedef logic [`PERIPH_NUM_TIMERS-1:0] irq_vec_t;
  typedef logic [`PERIPH_IRQ_ID_W-1:0]   irq_id_t;

  // Word offsets inside the event unit window
  typedef enum logic [1:0] {
    MASK    = 2'd0,
    PENDING = 2'd1,
    IRQ_ID  = 2'd2
  } evu_reg_e;

endpackage

// ==== logic/wb_periph_decoder.sv ====
`timescale 1ns/10ps

`include "periph_defines.svh"

module wb_periph_decoder (
  input  logic                 core_clk,
  input  logic                 reset_n,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  bus_pkg::addr_t       wb_adr_i,
  input  bus_pkg::data_t       wb_dat_i,
  input  bus_pkg::data_t       chan_rdata_i [`PERIPH_NUM_TIMERS],
  input  bus_pkg::data_t       evu_rdata_i,
  output bus_pkg::data_t       wb_dat_o,
  output logic                 wb_ack_o,
  output irq_pkg::irq_vec_t    chan_we_o,
  output logic                 evu_we_o,
  output bus_pkg::timer_reg_e  reg_o,
  output bus_pkg::data_t       wdata_o
);

  localparam int CHAN_SPAN  = `PERIPH_NUM_TIMERS * `PERIPH_CHAN_STRIDE;
  localparam int SEL_LSB    = $clog2(`PERIPH_CHAN_STRIDE);
  localparam int SEL_W      = $clog2(`PERIPH_NUM_TIMERS);
  localparam int REG_W      = $bits(bus_pkg::timer_reg_e);

  bus_pkg::wb_state_e   state_q;
  bus_pkg::wb_state_e   state_d;
  logic                 req_accept;
  logic                 hit_chan;
  logic                 hit_evu;
  logic [SEL_W-1:0]     chan_sel;
  bus_pkg::data_t       rd_mux;

  // New request only seen while idle, so ack can never repeat
  assign req_accept = wb_cyc_i && wb_stb_i && (state_q == bus_pkg::IDLE);

  assign hit_chan = (wb_adr_i < CHAN_SPAN);
  assign hit_evu  = (wb_adr_i >= `PERIPH_EVU_BASE) &&
                    (wb_adr_i < (`PERIPH_EVU_BASE + `PERIPH_CHAN_STRIDE));
  assign chan_sel = wb_adr_i[SEL_LSB +: SEL_W];

  // Word offset is shared by every target
  assign reg_o   = bus_pkg::timer_reg_e'(wb_adr_i[2 +: REG_W]);
  assign wdata_o = wb_dat_i;

  always_comb begin
    chan_we_o = '0;
    evu_we_o  = 1'b0;
    if (req_accept && wb_we_i) begin
      if (hit_chan) begin
        chan_we_o[chan_sel] = 1'b1;
      end else if (hit_evu) begin
        evu_we_o = 1'b1;
      end
    end
  end

  // Unmapped space reads as zero
  always_comb begin
    rd_mux = '0;
    if (hit_chan) begin
      rd_mux = chan_rdata_i[chan_sel];
    end else if (hit_evu) begin
      rd_mux = evu_rdata_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      bus_pkg::IDLE: begin
        if (wb_cyc_i && wb_stb_i) begin
          state_d = bus_pkg::ACK;
        end
      end
      bus_pkg::ACK:  state_d = bus_pkg::IDLE;
      default:       state_d = bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= bus_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_accept) begin
      wb_dat_o <= wb_we_i ? '0 : rd_mux;
    end
  end

  assign wb_ack_o = (state_q == bus_pkg::ACK);

endmodule

// ==== logic/timer_channel.sv ====
`timescale 1ns/10ps

module timer_channel (
  input  logic                 core_clk,
  input  logic                 reset_n,
  input  logic                 we_i,
  input  bus_pkg::timer_reg_e  reg_i,
  input  bus_pkg::data_t       wdata_i,
  output bus_pkg::data_t       rdata_o,
  output logic                 pending_o
);

  bus_pkg::data_t  count_q;
  bus_pkg::data_t  compare_q;
  logic            enable_q;
  logic            pending_q;
  logic            match;

  assign match = enable_q && (count_q == compare_q);

  // Bus write beats the counter, reload on match
  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      count_q <= '0;
    end else if (we_i && (reg_i == bus_pkg::COUNT)) begin
      count_q <= wdata_i;
    end else if (match) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      compare_q <= '0;
      enable_q  <= 1'b0;
    end else if (we_i) begin
      if (reg_i == bus_pkg::COMPARE) begin
        compare_q <= wdata_i;
      end
      if (reg_i == bus_pkg::CTRL) begin
        enable_q <= wdata_i[0];
      end
    end
  end

  // A new match wins over a clear in the same cycle
  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      pending_q <= 1'b0;
    end else if (match) begin
      pending_q <= 1'b1;
    end else if (we_i && (reg_i == bus_pkg::STATUS) && wdata_i[0]) begin
      pending_q <= 1'b0;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (reg_i)
      bus_pkg::COUNT:   rdata_o    = count_q;
      bus_pkg::COMPARE: rdata_o    = compare_q;
      bus_pkg::CTRL:    rdata_o[0] = enable_q;
      bus_pkg::STATUS:  rdata_o[0] = pending_q;
      default:          rdata_o    = '0;
    endcase
  end

  assign pending_o = pending_q;

endmodule

// ==== logic/irq_event_unit.sv ====
`timescale 1ns/10ps

`include "periph_defines.svh"

module irq_event_unit (
  input  logic                core_clk,
  input  logic                reset_n,
  input  logic                we_i,
  input  irq_pkg::evu_reg_e   reg_i,
  input  bus_pkg::data_t      wdata_i,
  input  irq_pkg::irq_vec_t   pending_i,
  output bus_pkg::data_t      rdata_o,
  output logic                irq_o,
  output irq_pkg::irq_id_t    irq_id_o
);

  // Position of the any-pending flag in IRQ_ID
  localparam int IRQ_VALID_BIT = 8;

  irq_pkg::irq_vec_t  mask_q;
  irq_pkg::irq_vec_t  active;
  irq_pkg::irq_id_t   id_d;
  logic               irq_q;
  irq_pkg::irq_id_t   id_q;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      mask_q <= '0;
    end else if (we_i && (reg_i == irq_pkg::MASK)) begin
      mask_q <= wdata_i[`PERIPH_NUM_TIMERS-1:0];
    end
  end

  assign active = mask_q & pending_i;

  // Highest set index wins
  always_comb begin
    id_d = '0;
    for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
      if (active[i]) begin
        id_d = irq_pkg::irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      irq_q <= 1'b0;
      id_q  <= '0;
    end else begin
      irq_q <= |active;
      id_q  <= id_d;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (reg_i)
      irq_pkg::MASK:    rdata_o[`PERIPH_NUM_TIMERS-1:0] = mask_q;
      irq_pkg::PENDING: rdata_o[`PERIPH_NUM_TIMERS-1:0] = pending_i;
      irq_pkg::IRQ_ID: begin
        rdata_o[`PERIPH_IRQ_ID_W-1:0] = id_q;
        rdata_o[IRQ_VALID_BIT]        = irq_q;
      end
      default:          rdata_o = '0;
    endcase
  end

  assign irq_o    = irq_q;
  assign irq_id_o = id_q;

endmodule

// ==== logic/periph_subsystem_top.sv ====
`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_subsystem_top (
  input  logic              core_clk,
  input  logic              reset_n,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  bus_pkg::addr_t    wb_adr_i,
  input  bus_pkg::data_t    wb_dat_i,
  output bus_pkg::data_t    wb_dat_o,
  output logic              wb_ack_o,
  output logic              irq_o,
  output irq_pkg::irq_id_t  irq_id_o
);

  bus_pkg::data_t       chan_rdata [`PERIPH_NUM_TIMERS];
  irq_pkg::irq_vec_t    chan_we;
  irq_pkg::irq_vec_t    chan_pending;
  logic                 evu_we;
  bus_pkg::timer_reg_e  reg_sel;
  bus_pkg::data_t       wdata;
  bus_pkg::data_t       evu_rdata;

  wb_periph_decoder u_decoder (
    .core_clk     (core_clk),
    .reset_n      (reset_n),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .chan_rdata_i (chan_rdata),
    .evu_rdata_i  (evu_rdata),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .chan_we_o    (chan_we),
    .evu_we_o     (evu_we),
    .reg_o        (reg_sel),
    .wdata_o      (wdata)
  );

  for (genvar k = 0; k < `PERIPH_NUM_TIMERS; k++) begin : g_timer
    timer_channel u_timer (
      .core_clk  (core_clk),
      .reset_n   (reset_n),
      .we_i      (chan_we[k]),
      .reg_i     (reg_sel),
      .wdata_i   (wdata),
      .rdata_o   (chan_rdata[k]),
      .pending_o (chan_pending[k])
    );
  end

  // Same word offset, event unit view of it
  irq_event_unit u_evu (
    .core_clk  (core_clk),
    .reset_n   (reset_n),
    .we_i      (evu_we),
    .reg_i     (irq_pkg::evu_reg_e'(reg_sel)),
    .wdata_i   (wdata),
    .pending_i (chan_pending),
    .rdata_o   (evu_rdata),
    .irq_o     (irq_o),
    .irq_id_o  (irq_id_o)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic core_clk,
  output logic reset_n
);

  localparam int RESET_CYCLES = 16;

  // 10 ns period
  initial begin
    core_clk = 1'b0;
    forever #5 core_clk = ~core_clk;
  end

  // Release away from the rising edge
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge core_clk);
    @(negedge core_clk);
    reset_n = 1'b1;
  end

endmodule

// ==== tb/periph_props.sv ====
`timescale 1ns/10ps

module periph_props (
  input logic core_clk,
  input logic reset_n,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i
);

  // Running count of assertion failures
  int unsigned fail_count = 0;

  ack_needs_req: assert property (@(posedge core_clk) disable iff (!reset_n)
    ack_i |-> (cyc_i && stb_i))
    else begin
      fail_count++;
      $error("ack asserted without cyc and stb");
    end

  ack_one_cycle: assert property (@(posedge core_clk) disable iff (!reset_n)
    ack_i |=> !ack_i)
    else begin
      fail_count++;
      $error("ack held high for two cycles");
    end

  ack_low_in_reset: assert property (@(posedge core_clk) !reset_n |-> !ack_i)
    else begin
      fail_count++;
      $error("ack high during reset");
    end

endmodule

// ==== tb/periph_tb.sv ====
`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_tb;

  localparam int N           = `PERIPH_NUM_TIMERS;
  localparam int IRQ_ROUNDS  = 6;
  // About 155 transfers over all phases
  localparam int MAX_ACCESSES   = 160;
  localparam int WAIT_CYCLES    = 4 * 16 + 2 * IRQ_ROUNDS + 8;
  localparam int TIMEOUT_CYCLES = 16 + MAX_ACCESSES * 20 + WAIT_CYCLES;

  logic              core_clk;
  logic              reset_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  bus_pkg::addr_t    wb_adr;
  bus_pkg::data_t    wb_dat_wr;
  bus_pkg::data_t    wb_dat_rd;
  logic              wb_ack;
  logic              irq;
  irq_pkg::irq_id_t  irq_id;

  logic [15:0]       lfsr_q = 16'd47;
  int                data_errs = 0;
  int                id_errs = 0;
  bus_pkg::data_t    exp_q [$];
  bit                chk_q [$];

  tb_clock_gen u_clk (.core_clk(core_clk), .reset_n(reset_n));

  periph_subsystem_top DUT (
    .core_clk (core_clk),
    .reset_n  (reset_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_wr),
    .wb_dat_o (wb_dat_rd),
    .wb_ack_o (wb_ack),
    .irq_o    (irq),
    .irq_id_o (irq_id)
  );

  bind wb_periph_decoder periph_props u_props (
    .core_clk (core_clk),
    .reset_n  (reset_n),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .ack_i    (wb_ack_o)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output bus_pkg::data_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[`PERIPH_DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  // Expected IRQ_ID word, search down from the top channel
  function automatic bus_pkg::data_t irq_id_ref(input irq_pkg::irq_vec_t pend,
                                                input irq_pkg::irq_vec_t mask);
    bus_pkg::data_t w;
    int             i;
    w = '0;
    i = N - 1;
    while (i >= 0 && !(pend[i] && mask[i])) begin
      i--;
    end
    if (i >= 0) begin
      w[`PERIPH_IRQ_ID_W-1:0] = i[`PERIPH_IRQ_ID_W-1:0];
      w[8] = 1'b1;
    end
    return w;
  endfunction

  function automatic bus_pkg::addr_t chan_addr(input int k, input bus_pkg::timer_reg_e r);
    return bus_pkg::addr_t'(k * `PERIPH_CHAN_STRIDE + 4 * int'(r));
  endfunction

  function automatic bus_pkg::addr_t evu_addr(input irq_pkg::evu_reg_e r);
    return bus_pkg::addr_t'(`PERIPH_EVU_BASE + 4 * int'(r));
  endfunction

  task automatic check_data(input bus_pkg::data_t got, input bus_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      data_errs++;
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_irq_id(input irq_pkg::irq_id_t got, input irq_pkg::irq_id_t exp,
                              input string what);
    if (got !== exp) begin
      id_errs++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic bus_access(input logic we, input bus_pkg::addr_t adr,
                            input bus_pkg::data_t wdata, output bus_pkg::data_t rdata);
    @(posedge core_clk);
    wb_cyc    <= 1'b1;
    wb_stb    <= 1'b1;
    wb_we     <= we;
    wb_adr    <= adr;
    wb_dat_wr <= wdata;
    do begin
      @(negedge core_clk);
    end while (!wb_ack);
    rdata = wb_dat_rd;
    @(posedge core_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_write(input bus_pkg::addr_t adr, input bus_pkg::data_t wdata);
    bus_pkg::data_t unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  task automatic read_expect(input bus_pkg::addr_t adr, input bus_pkg::data_t exp);
    bus_pkg::data_t rd;
    exp_q.push_back(exp);
    chk_q.push_back(1'b1);
    bus_access(1'b0, adr, '0, rd);
  endtask

  task automatic bus_read(input bus_pkg::addr_t adr, output bus_pkg::data_t rdata);
    exp_q.push_back('0);
    chk_q.push_back(1'b0);
    bus_access(1'b0, adr, '0, rdata);
  endtask

  // Read data is valid while ack is high
  always @(negedge core_clk) begin : compare_reads
    bus_pkg::data_t exp;
    bit             chk;
    if (wb_ack && !wb_we && exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      chk = chk_q.pop_front();
      if (chk) begin
        check_data(wb_dat_rd, exp, $sformatf("read of 0x%03h", wb_adr));
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge core_clk);
    $display("Timeout: test sequence did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : stimulus
    bus_pkg::data_t     val;
    bus_pkg::data_t     cmp;
    bus_pkg::data_t     rd;
    bus_pkg::data_t     exp_word;
    irq_pkg::irq_vec_t  subset;
    irq_pkg::irq_vec_t  mask;
    int                 k;
    int                 asrt_errs;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_wr = '0;
    wait (reset_n === 1'b1);
    @(negedge core_clk);

    // Reset values
    check_data(bus_pkg::data_t'(irq), '0, "irq_o after reset");
    for (int c = 0; c < N; c++) begin
      read_expect(chan_addr(c, bus_pkg::COMPARE), '0);
      read_expect(chan_addr(c, bus_pkg::CTRL), '0);
      read_expect(chan_addr(c, bus_pkg::STATUS), '0);
    end
    read_expect(evu_addr(irq_pkg::MASK), '0);

    // Readback on disabled channels
    for (int c = 0; c < N; c++) begin
      rand_bits(32, val);
      bus_write(chan_addr(c, bus_pkg::COMPARE), val);
      read_expect(chan_addr(c, bus_pkg::COMPARE), val);
      rand_bits(32, val);
      bus_write(chan_addr(c, bus_pkg::COUNT), val);
      read_expect(chan_addr(c, bus_pkg::COUNT), val);
    end
    rand_bits(N, val);
    bus_write(evu_addr(irq_pkg::MASK), val);
    read_expect(evu_addr(irq_pkg::MASK), val);

    // Compare match on one channel
    rand_bits(`PERIPH_IRQ_ID_W, val);
    k = int'(val);
    rand_bits(4, cmp);
    bus_write(chan_addr(k, bus_pkg::COUNT), '0);
    bus_write(chan_addr(k, bus_pkg::COMPARE), cmp);
    bus_write(chan_addr(k, bus_pkg::CTRL), 32'd1);
    repeat (4 * (int'(cmp) + 1)) @(posedge core_clk);
    read_expect(chan_addr(k, bus_pkg::STATUS), 32'd1);
    bus_read(chan_addr(k, bus_pkg::COUNT), rd);
    if (rd > cmp) begin
      data_errs++;
      $display("Error at %0t ns: channel %0d COUNT %0d above COMPARE %0d", $time, k, rd, cmp);
    end

    // Disable and clear
    bus_write(chan_addr(k, bus_pkg::CTRL), '0);
    bus_write(chan_addr(k, bus_pkg::STATUS), 32'd1);
    read_expect(chan_addr(k, bus_pkg::STATUS), '0);

    for (int r = 0; r < IRQ_ROUNDS; r++) begin
      rand_bits(N, val);
      subset = val[N-1:0];
      // COMPARE 0 matches on the first enabled cycle
      for (int c = 0; c < N; c++) begin
        if (subset[c]) begin
          bus_write(chan_addr(c, bus_pkg::COMPARE), '0);
          bus_write(chan_addr(c, bus_pkg::COUNT), '0);
          bus_write(chan_addr(c, bus_pkg::CTRL), 32'd1);
          bus_write(chan_addr(c, bus_pkg::CTRL), '0);
        end else begin
          bus_write(chan_addr(c, bus_pkg::CTRL), '0);
          bus_write(chan_addr(c, bus_pkg::STATUS), 32'd1);
        end
      end
      rand_bits(N, val);
      mask = val[N-1:0];
      bus_write(evu_addr(irq_pkg::MASK), val);
      repeat (2) @(posedge core_clk);
      @(negedge core_clk);
      exp_word = irq_id_ref(subset, mask);
      check_data(bus_pkg::data_t'(irq), bus_pkg::data_t'(exp_word[8]), "irq_o");
      check_irq_id(irq_id, exp_word[`PERIPH_IRQ_ID_W-1:0], "irq_id_o");
      read_expect(evu_addr(irq_pkg::IRQ_ID), exp_word);
      read_expect(evu_addr(irq_pkg::PENDING), bus_pkg::data_t'(subset));
    end

    // Unmapped space
    read_expect(12'h080, '0);
    read_expect(12'hff0, '0);

    repeat (2) @(posedge core_clk);
    asrt_errs = int'(DUT.u_decoder.u_props.fail_count);
    $display("Mismatch counts: data %0d, irq id %0d, assertion %0d",
             data_errs, id_errs, asrt_errs);
    if (data_errs + id_errs + asrt_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/bus_pkg.sv
logic/irq_pkg.sv
logic/wb_periph_decoder.sv
logic/timer_channel.sv
logic/irq_event_unit.sv
logic/periph_subsystem_top.sv
tb/tb_clock_gen.sv
tb/periph_props.sv
tb/periph_tb.sv

// ==== Bender.yml ====
package:
  name: periph_subsystem

sources:
  - include_dirs:
      - logic
    files:
      - logic/bus_pkg.sv
      - logic/irq_pkg.sv
      - logic/wb_periph_decoder.sv
      - logic/timer_channel.sv
      - logic/irq_event_unit.sv
      - logic/periph_subsystem_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/tb_clock_gen.sv
      - tb/periph_props.sv
      - tb/periph_tb.sv
